//--- verilog/sd_pkg.sv
// SD host controller shared definitions: register map, opcodes, status codes and timing constants
package sd_pkg;

    // Operation opcodes as written to the control word
    typedef enum logic [1:0] {
        OP_READ  = 2'd2,
        OP_WRITE = 2'd3
    } sd_op_e;

    // Status word codes
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd2,
        ST_READ  = 3'd3,
        ST_WRITE = 3'd4,
        ST_ERROR = 3'd5
    } sd_status_e;

    // Register write addresses
    localparam logic [2:0] REG_BASE  = 3'd0;    // Memory base address
    localparam logic [2:0] REG_LBA   = 3'd1;    // Card block address
    localparam logic [2:0] REG_COUNT = 3'd2;    // Number of blocks
    localparam logic [2:0] REG_CTRL  = 3'd3;    // Opcode in bits 1:0

    // Register read addresses, 1 to 3 return the mutex
    localparam logic [2:0] RD_STATUS = 3'd0;
    localparam logic [2:0] RD_BASE   = 3'd4;
    localparam logic [2:0] RD_LBA    = 3'd5;
    localparam logic [2:0] RD_COUNT  = 3'd6;

    // Memory stride of one card block
    localparam logic [31:0] BLOCK_BYTES = 32'd512;

    // Cycles the card gets to raise ack after card_req
    localparam logic [7:0] LINK_TIMEOUT = 8'd64;

endpackage

//--- verilog/sd_regs.sv
// SD host register window with mutex, control decoding and status tracking
module sd_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [2:0]         reg_addr,
    input  logic               reg_read,
    output logic [31:0]        reg_rdata,
    input  logic               reg_write,
    input  logic [31:0]        reg_wdata,
    output logic               op_req,
    output sd_pkg::sd_op_e     op_kind,
    output logic [31:0]        op_base,
    output logic [31:0]        op_lba,
    output logic [31:0]        op_count,
    input  logic               op_ack,
    input  logic               op_err
);

    logic [31:0]        base_q;
    logic [31:0]        lba_q;
    logic [31:0]        count_q;
    logic [2:0]         mutex_q;
    sd_pkg::sd_status_e status_q;
    logic               idle;
    logic               ctrl_wr;
    logic               start_rd;
    logic               start_wr;
    logic               start;
    logic               done;
    logic               claim;

    assign idle     = !op_req;                  // No operation in flight
    assign ctrl_wr  = idle && reg_write && reg_addr == sd_pkg::REG_CTRL;
    assign start_rd = ctrl_wr && reg_wdata[1:0] == sd_pkg::OP_READ;
    assign start_wr = ctrl_wr && reg_wdata[1:0] == sd_pkg::OP_WRITE;
    assign start    = start_rd || start_wr;     // Other opcodes are dropped
    assign done     = op_req && op_ack;         // One cycle, op_req falls next
    assign claim    = mutex_q == 3'd0 && reg_read &&
                      reg_addr inside {3'd1, 3'd2, 3'd3};

    // Operands stay stable for the sequencer since writes are locked out
    assign op_base  = base_q;
    assign op_lba   = lba_q;
    assign op_count = count_q;

    always_comb begin
        case (reg_addr)
            sd_pkg::RD_STATUS:  reg_rdata = {29'd0, status_q};
            3'd1, 3'd2, 3'd3:   reg_rdata = {29'd0, mutex_q};
            sd_pkg::RD_BASE:    reg_rdata = base_q;
            sd_pkg::RD_LBA:     reg_rdata = lba_q;
            sd_pkg::RD_COUNT:   reg_rdata = count_q;
            default:            reg_rdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q  <= 32'd0;
            lba_q   <= 32'd0;
            count_q <= 32'd0;
        end else if (idle && reg_write) begin
            if (reg_addr == sd_pkg::REG_BASE) begin
                base_q <= reg_wdata;
            end
            if (reg_addr == sd_pkg::REG_LBA) begin
                lba_q <= reg_wdata;
            end
            if (reg_addr == sd_pkg::REG_COUNT) begin
                count_q <= reg_wdata;
            end
        end
    end

    // Slot value 4 marks the controller itself as owner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mutex_q <= 3'd0;
        end else if (start) begin
            mutex_q <= 3'd4;
        end else if (done) begin
            mutex_q <= 3'd0;
        end else if (claim) begin
            mutex_q <= reg_addr;                // Reading slot k claims k
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_req   <= 1'b0;
            status_q <= sd_pkg::ST_IDLE;
        end else if (start) begin
            op_req   <= 1'b1;
            status_q <= start_wr ? sd_pkg::ST_WRITE : sd_pkg::ST_READ;
        end else if (done) begin
            op_req   <= 1'b0;
            status_q <= op_err ? sd_pkg::ST_ERROR : sd_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_kind <= start_wr ? sd_pkg::OP_WRITE : sd_pkg::OP_READ;
        end
    end

endmodule

//--- verilog/sd_block_seq.sv
// SD block sequencer: splits an operation into single-block card commands
module sd_block_seq (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               op_req,
    input  sd_pkg::sd_op_e     op_kind,
    input  logic [31:0]        op_base,
    input  logic [31:0]        op_lba,
    input  logic [31:0]        op_count,
    output logic               op_ack,
    output logic               op_err,
    output logic               blk_req,
    output sd_pkg::sd_op_e     blk_kind,
    output logic [31:0]        blk_lba,
    output logic [31:0]        blk_mem,
    input  logic               blk_ack,
    input  logic               blk_err
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_DONE
    } seq_state_e;

    seq_state_e  state;
    logic [31:0] remain;                        // Blocks not yet acknowledged
    logic        err_q;
    logic        load;
    logic        step;

    assign load   = state == S_IDLE && op_req;
    // Next block only once the link has released ack and nothing failed
    assign step   = state == S_WAIT && !blk_ack && !err_q && remain != 32'd0;
    assign op_err = err_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            remain  <= 32'd0;
            err_q   <= 1'b0;
            blk_req <= 1'b0;
            op_ack  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (op_req) begin
                        remain <= op_count;
                        err_q  <= 1'b0;
                        if (op_count == 32'd0) begin
                            op_ack <= 1'b1;     // Empty operation, no card traffic
                            state  <= S_DONE;
                        end else begin
                            blk_req <= 1'b1;
                            state   <= S_ISSUE;
                        end
                    end
                end
                S_ISSUE: begin
                    if (blk_ack) begin
                        blk_req <= 1'b0;
                        err_q   <= blk_err;
                        remain  <= remain - 32'd1;
                        state   <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (step) begin
                        blk_req <= 1'b1;
                        state   <= S_ISSUE;
                    end else if (!blk_ack) begin
                        op_ack <= 1'b1;         // Last block or first failure
                        state  <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (!op_req) begin
                        op_ack <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            blk_kind <= op_kind;
            blk_lba  <= op_lba;
            blk_mem  <= op_base;
        end else if (step) begin
            blk_lba <= blk_lba + 32'd1;
            blk_mem <= blk_mem + sd_pkg::BLOCK_BYTES;
        end
    end

endmodule

//--- verilog/sd_card_link.sv
// SD card link: four-phase card exchange per block with response timeout
module sd_card_link (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               blk_req,
    input  sd_pkg::sd_op_e     blk_kind,
    input  logic [31:0]        blk_lba,
    input  logic [31:0]        blk_mem,
    output logic               blk_ack,
    output logic               blk_err,
    output logic               card_req,
    output logic               card_write,
    output logic [31:0]        card_lba,
    output logic [31:0]        card_mem,
    input  logic               card_ack,
    input  logic               card_err
);

    typedef enum logic [1:0] {
        L_IDLE,
        L_REQUEST,
        L_RELEASE,
        L_REPLY
    } link_state_e;

    link_state_e state;
    logic [7:0]  tmo_cnt;                       // Cycles since card_req rose
    logic        err_q;
    logic        launch;

    assign launch  = state == L_IDLE && blk_req;
    assign blk_err = err_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= L_IDLE;
            tmo_cnt  <= 8'd0;
            err_q    <= 1'b0;
            card_req <= 1'b0;
            blk_ack  <= 1'b0;
        end else begin
            case (state)
                L_IDLE: begin
                    if (blk_req) begin
                        card_req <= 1'b1;
                        tmo_cnt  <= 8'd0;
                        state    <= L_REQUEST;
                    end
                end
                L_REQUEST: begin
                    if (card_ack) begin
                        card_req <= 1'b0;
                        err_q    <= card_err;
                        state    <= L_RELEASE;
                    end else if (tmo_cnt == sd_pkg::LINK_TIMEOUT) begin
                        card_req <= 1'b0;       // Card gave up on, no ack expected
                        err_q    <= 1'b1;
                        blk_ack  <= 1'b1;
                        state    <= L_REPLY;
                    end else begin
                        tmo_cnt <= tmo_cnt + 8'd1;
                    end
                end
                L_RELEASE: begin
                    if (!card_ack) begin
                        blk_ack <= 1'b1;
                        state   <= L_REPLY;
                    end
                end
                L_REPLY: begin
                    if (!blk_req) begin
                        blk_ack <= 1'b0;
                        state   <= L_IDLE;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // Card fields held for the whole exchange
    always_ff @(posedge clk) begin
        if (launch) begin
            card_write <= blk_kind == sd_pkg::OP_WRITE;
            card_lba   <= blk_lba;
            card_mem   <= blk_mem;
        end
    end

endmodule

//--- verilog/sd_host_top.sv
// SD host controller top: register window, block sequencer and card link in a chain
module sd_host_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [2:0]         reg_addr,
    input  logic               reg_read,
    output logic [31:0]        reg_rdata,
    input  logic               reg_write,
    input  logic [31:0]        reg_wdata,
    output logic               card_req,
    output logic               card_write,
    output logic [31:0]        card_lba,
    output logic [31:0]        card_mem,
    input  logic               card_ack,
    input  logic               card_err
);

    // Register stage to sequencer
    logic               op_req;
    sd_pkg::sd_op_e     op_kind;
    logic [31:0]        op_base;
    logic [31:0]        op_lba;
    logic [31:0]        op_count;
    logic               op_ack;
    logic               op_err;

    // Sequencer to card link
    logic               blk_req;
    sd_pkg::sd_op_e     blk_kind;
    logic [31:0]        blk_lba;
    logic [31:0]        blk_mem;
    logic               blk_ack;
    logic               blk_err;

    sd_regs i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_read  (reg_read),
        .reg_rdata (reg_rdata),
        .reg_write (reg_write),
        .reg_wdata (reg_wdata),
        .op_req    (op_req),
        .op_kind   (op_kind),
        .op_base   (op_base),
        .op_lba    (op_lba),
        .op_count  (op_count),
        .op_ack    (op_ack),
        .op_err    (op_err)
    );

    sd_block_seq i_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_req   (op_req),
        .op_kind  (op_kind),
        .op_base  (op_base),
        .op_lba   (op_lba),
        .op_count (op_count),
        .op_ack   (op_ack),
        .op_err   (op_err),
        .blk_req  (blk_req),
        .blk_kind (blk_kind),
        .blk_lba  (blk_lba),
        .blk_mem  (blk_mem),
        .blk_ack  (blk_ack),
        .blk_err  (blk_err)
    );

    sd_card_link i_link (
        .clk        (clk),
        .rst_n      (rst_n),
        .blk_req    (blk_req),
        .blk_kind   (blk_kind),
        .blk_lba    (blk_lba),
        .blk_mem    (blk_mem),
        .blk_ack    (blk_ack),
        .blk_err    (blk_err),
        .card_req   (card_req),
        .card_write (card_write),
        .card_lba   (card_lba),
        .card_mem   (card_mem),
        .card_ack   (card_ack),
        .card_err   (card_err)
    );

endmodule

//--- verif/tb_sd_host.sv
// SD host testbench driving random register and block traffic against a reference model
module tb_sd_host;

    localparam int NUM_OPS     = 7;
    localparam int MAX_BLOCKS  = 5;
    localparam int CYCLE_LIMIT = 16 + NUM_OPS * (MAX_BLOCKS * (sd_pkg::LINK_TIMEOUT + 40) + 100);

    logic        clk;
    logic        rst_n;
    logic [2:0]  reg_addr;
    logic        reg_read;
    logic [31:0] reg_rdata;
    logic        reg_write;
    logic [31:0] reg_wdata;
    logic        card_req;
    logic        card_write;
    logic [31:0] card_lba;
    logic [31:0] card_mem;
    logic        card_ack;
    logic        card_err;

    logic [31:0] rng_state;
    int          cycles;
    int          checks;
    int          errors;
    int          tests;
    int          failed;
    int          test_errors;                   // Errors before the current test
    logic [2:0]  mdl_mutex;                     // Expected mutex value

    // Card behavior for the current operation
    int          delay_tab [MAX_BLOCKS];
    int          err_blk;
    int          hang_blk;
    logic        hang_seen;
    logic [31:0] seen_lba [$];
    logic [31:0] seen_mem [$];
    logic        seen_wr  [$];

    sd_host_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_addr   (reg_addr),
        .reg_read   (reg_read),
        .reg_rdata  (reg_rdata),
        .reg_write  (reg_write),
        .reg_wdata  (reg_wdata),
        .card_req   (card_req),
        .card_write (card_write),
        .card_lba   (card_lba),
        .card_mem   (card_mem),
        .card_ack   (card_ack),
        .card_err   (card_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // Card model that answers each request four-phase and logs it
    initial begin : card_responder
        int idx;
        card_ack = 1'b0;
        card_err = 1'b0;
        forever begin
            @(negedge clk);
            if (card_req && !card_ack) begin
                idx = seen_lba.size();
                seen_lba.push_back(card_lba);
                seen_mem.push_back(card_mem);
                seen_wr.push_back(card_write);
                if (idx == hang_blk) begin
                    while (card_req) @(negedge clk);    // Silent card so the link has to give up
                    hang_seen = 1'b1;
                end else begin
                    repeat (delay_tab[idx % MAX_BLOCKS]) @(negedge clk);
                    card_err = idx == err_blk;
                    card_ack = 1'b1;
                    while (card_req) @(negedge clk);
                    card_ack = 1'b0;
                    card_err = 1'b0;
                end
            end
        end
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        reg_addr  = addr;
        reg_wdata = data;
        reg_write = 1'b1;
        @(negedge clk);
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
        reg_addr = addr;
        reg_read = 1'b1;
        @(posedge clk);
        data = reg_rdata;                       // Value seen by the strobe edge
        @(negedge clk);
        reg_read = 1'b0;
    endtask

    task automatic expect_reg(input logic [2:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] data;
        read_reg(addr, data);
        check_value(data, exp, what);
    endtask

    task automatic read_mutex(input logic [2:0] slot);
        logic [31:0] exp;
        exp = {29'd0, mdl_mutex};
        expect_reg(slot, exp, "mutex");
        if (mdl_mutex == 3'd0) begin
            mdl_mutex = slot;                   // Free slot read claims it
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        read_reg(sd_pkg::RD_STATUS, status);
        while (status[2:0] == sd_pkg::ST_READ || status[2:0] == sd_pkg::ST_WRITE) begin
            read_reg(sd_pkg::RD_STATUS, status);
        end
    endtask

    // One operation checked against the model
    // fail_at and hang_at are -1 when unused
    task automatic run_op(input sd_pkg::sd_op_e kind, input int count, input int fail_at,
                          input int hang_at, input bit poke);
        logic [31:0] base;
        logic [31:0] lba;
        logic [31:0] status;
        logic [31:0] exp_status;
        int          expect_n;
        int          i;
        base = xorshift();
        lba  = xorshift();
        for (i = 0; i < MAX_BLOCKS; i++) begin
            delay_tab[i] = xorshift() % 11;
        end
        err_blk   = fail_at;
        hang_blk  = hang_at;
        hang_seen = 1'b0;
        seen_lba.delete();
        seen_mem.delete();
        seen_wr.delete();
        write_reg(sd_pkg::REG_BASE, base);
        write_reg(sd_pkg::REG_LBA, lba);
        write_reg(sd_pkg::REG_COUNT, count);
        write_reg(sd_pkg::REG_CTRL, {30'd0, kind});
        mdl_mutex  = 3'd4;
        exp_status = kind == sd_pkg::OP_WRITE ? sd_pkg::ST_WRITE : sd_pkg::ST_READ;
        expect_reg(sd_pkg::RD_STATUS, exp_status, "busy status");
        read_mutex(3'd1 + 3'(xorshift() % 3));
        if (poke) begin
            // All of these land while busy and must be dropped
            write_reg(sd_pkg::REG_BASE, ~base);
            write_reg(sd_pkg::REG_LBA, ~lba);
            write_reg(sd_pkg::REG_COUNT, count + 1);
            write_reg(sd_pkg::REG_CTRL, {30'd0, sd_pkg::OP_READ});
            expect_reg(sd_pkg::RD_STATUS, exp_status, "status after locked control write");
        end
        wait_done(status);
        mdl_mutex = 3'd0;
        expect_n  = count;
        if (fail_at >= 0) begin
            expect_n = fail_at + 1;
        end
        if (hang_at >= 0) begin
            expect_n = hang_at + 1;
        end
        exp_status = (fail_at >= 0 || hang_at >= 0) ? sd_pkg::ST_ERROR : sd_pkg::ST_IDLE;
        check_value(status, exp_status, "final status");
        check_value(seen_lba.size(), expect_n, "request count");
        for (i = 0; i < seen_lba.size() && i < expect_n; i++) begin
            check_value(seen_lba[i], lba + i, "card_lba");
            check_value(seen_mem[i], base + i * sd_pkg::BLOCK_BYTES, "card_mem");
            check_value(seen_wr[i], kind == sd_pkg::OP_WRITE, "card_write");
        end
        if (hang_at >= 0) begin
            checks++;
            assert (hang_seen) else begin
                $display("The link never dropped card_req on the block the card ignored");
                errors++;
            end
        end
        expect_reg(sd_pkg::RD_BASE, base, "base after operation");
        expect_reg(sd_pkg::RD_LBA, lba, "lba after operation");
        expect_reg(sd_pkg::RD_COUNT, count, "count after operation");
        read_mutex(3'd1 + 3'(xorshift() % 3));
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("Test %s: passed", name);
        end else begin
            failed++;
            $display("Test %s: failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] val_base;
        logic [31:0] val_lba;
        logic [31:0] val_count;
        logic [2:0]  slot;
        int          cnt;
        rng_state   = 32'h1596252d;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        failed      = 0;
        test_errors = 0;
        mdl_mutex   = 3'd0;
        err_blk     = -1;
        hang_blk    = -1;
        hang_seen   = 1'b0;
        rst_n       = 1'b0;
        reg_addr    = 3'd0;
        reg_read    = 1'b0;
        reg_write   = 1'b0;
        reg_wdata   = 32'd0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        val_base  = xorshift();
        val_lba   = xorshift();
        val_count = xorshift() % 6;
        write_reg(sd_pkg::REG_BASE, val_base);
        write_reg(sd_pkg::REG_LBA, val_lba);
        write_reg(sd_pkg::REG_COUNT, val_count);
        expect_reg(sd_pkg::RD_BASE, val_base, "base");
        expect_reg(sd_pkg::RD_LBA, val_lba, "lba");
        expect_reg(sd_pkg::RD_COUNT, val_count, "count");
        expect_reg(sd_pkg::RD_STATUS, sd_pkg::ST_IDLE, "idle status");
        end_test("register readback");

        slot = 3'd1 + 3'(xorshift() % 3);
        read_mutex(slot);                       // Claims the slot
        read_mutex(slot);
        read_mutex(slot == 3'd3 ? 3'd1 : slot + 3'd1);
        run_op(sd_pkg::OP_READ, 2, -1, -1, 1'b0);
        end_test("mutex");

        run_op(sd_pkg::OP_READ, 0, -1, -1, 1'b0);
        run_op(sd_pkg::OP_READ, 1 + xorshift() % MAX_BLOCKS, -1, -1, 1'b0);
        end_test("read operation");

        run_op(sd_pkg::OP_WRITE, 2 + xorshift() % 4, -1, -1, 1'b1);
        end_test("write operation with locking");

        cnt = 1 + xorshift() % MAX_BLOCKS;
        run_op(sd_pkg::OP_WRITE, cnt, xorshift() % cnt, -1, 1'b0);
        run_op(sd_pkg::OP_READ, 1 + xorshift() % MAX_BLOCKS, -1, -1, 1'b0);
        end_test("card error");

        cnt = 2 + xorshift() % 4;
        run_op(sd_pkg::OP_READ, cnt, -1, xorshift() % cnt, 1'b0);
        end_test("card timeout");

        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/sd_pkg.sv
verilog/sd_regs.sv
verilog/sd_block_seq.sv
verilog/sd_card_link.sv
verilog/sd_host_top.sv
verif/tb_sd_host.sv

//--- Bender.yml
package:
  name: sd_host

sources:
  - verilog/sd_pkg.sv
  - verilog/sd_regs.sv
  - verilog/sd_block_seq.sv
  - verilog/sd_card_link.sv
  - verilog/sd_host_top.sv
  - target: simulation
    files:
      - verif/tb_sd_host.sv
